/* common/link_pkg.sv */
// Link package, beat layout, frame constant and header byte fields for the link receiver
`default_nettype none

package link_pkg;

  // ####################
  // Framing
  // ####################

  // All eight byte-lane frames set, beat is valid
  localparam logic [7:0] FRAME_ON = 8'hFF;

  // ####################
  // Header byte
  // ####################

  // Sits in the top byte of a head beat
  typedef struct packed {
    logic       write;     // 1 = write, 0 = read request
    logic [1:0] datamode;  // Access size
    logic [3:0] ctrlmode;  // Mesh control bits
    logic       spare;     // Unused
  } link_hdr_t;

  // ####################
  // Beat views
  // ####################

  // First beat of a packet
  typedef struct packed {
    link_hdr_t   hdr;      // [63:56]
    logic [23:0] spare;    // [55:32] unused
    logic [31:0] dstaddr;  // [31:0]
  } head_beat_t;

  // Second beat of a packet
  typedef struct packed {
    logic [31:0] data;     // [63:32]
    logic [31:0] srcaddr;  // [31:0]
  } tail_beat_t;

  // One 64-bit link word, read as head or tail by beat phase
  typedef union packed {
    head_beat_t head;
    tail_beat_t tail;
  } beat_t;

endpackage

`default_nettype wire

/* common/emesh_pkg.sv */
// Mesh package, transaction struct and receive buffer sizing for the mesh port
`default_nettype none

package emesh_pkg;

  // ####################
  // Buffer sizing
  // ####################

  localparam int RX_FIFO_DEPTH = 4;                       // Entries per channel
  localparam int RX_FIFO_AFULL = 2;                       // Wait threshold, entries in use
  localparam int RX_CNT_W      = 3;                       // Count width, holds 0..DEPTH
  localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);   // Pointer width

  // ####################
  // Transaction
  // ####################

  // Full mesh transaction, 103 bits
  // Field order follows the mesh port bundle
  typedef struct packed {
    logic        write;     // Write or read request
    logic [1:0]  datamode;  // Access size
    logic [3:0]  ctrlmode;  // Control bits
    logic [31:0] dstaddr;   // Target address
    logic [31:0] srcaddr;   // Return address for reads
    logic [31:0] data;      // Write data
  } emesh_tran_t;

endpackage

`default_nettype wire

/* link_rx/link_rx_fifo.sv */
// Receive FIFO, small circular buffer of mesh transactions with an almost-full flag
`timescale 1ns/1ps
`default_nettype none

module link_rx_fifo (
  input  logic                   rxi_lclk,    // Link clock
  input  logic                   reset,       // Sync reset, active high
  input  logic                   push,        // Write one entry
  input  emesh_pkg::emesh_tran_t push_tran,   // Entry to write
  input  logic                   pop,         // Drop the oldest entry
  output logic                   head_valid,  // At least one entry
  output emesh_pkg::emesh_tran_t head_tran,   // Oldest entry
  output logic                   afull        // Count at or above threshold
);
  import emesh_pkg::*;

  emesh_tran_t         mem [RX_FIFO_DEPTH];  // Storage
  logic [RX_PTR_W-1:0] wr_ptr;
  logic [RX_PTR_W-1:0] rd_ptr;
  logic [RX_CNT_W-1:0] count;                // Entries in use
  logic                full;
  logic                do_push;
  logic                do_pop;

  // Wrap at depth, not at pointer width
  function automatic logic [RX_PTR_W-1:0] ptr_inc(input logic [RX_PTR_W-1:0] ptr);
    ptr_inc = (ptr == RX_PTR_W'(RX_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == RX_CNT_W'(RX_FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && head_valid;

  // ####################
  // Storage
  // ####################

  always_ff @(posedge rxi_lclk) begin
    if (do_push)
      mem[wr_ptr] <= push_tran;
  end

  // ####################
  // Pointers and count
  // ####################

  always_ff @(posedge rxi_lclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;  // Fill
        2'b01:   count <= count - 1'b1;  // Drain
        default: count <= count;         // Both or neither
      endcase
    end
  end

  assign head_valid = (count != '0);
  assign head_tran  = mem[rd_ptr];                        // Valid only with head_valid
  assign afull      = (count >= RX_CNT_W'(RX_FIFO_AFULL));

  // Transmitter must honour the wait flag in time
  a_no_push_full: assert property (@(posedge rxi_lclk) disable iff (reset) push |-> !full)
    else $error("link_rx_fifo: push while full");

  // Arbiter must only pop a channel that offers something
  a_no_pop_empty: assert property (@(posedge rxi_lclk) disable iff (reset) pop |-> head_valid)
    else $error("link_rx_fifo: pop while empty");

endmodule

`default_nettype wire

/* link_rx/link_rx_channel.sv */
// Link channel receiver that frames beats into two-beat packets and buffers one direction
`timescale 1ns/1ps
`default_nettype none

module link_rx_channel #(
  parameter bit TAKE_WRITES = 1'b1              // 1 keeps writes, 0 keeps reads
) (
  input  logic                   rxi_lclk,      // Link clock
  input  logic                   reset,         // Sync reset, active high
  input  link_pkg::beat_t        rxi_data,      // One link beat
  input  logic [7:0]             rxi_frame,     // Byte-lane frames
  input  logic                   pop,           // From arbiter
  output logic                   head_valid,    // Packet waiting
  output emesh_pkg::emesh_tran_t head_tran,     // Oldest packet
  output logic                   rxo_wait       // Back toward transmitter
);
  import link_pkg::*;
  import emesh_pkg::*;

  // One-hot beat phase
  typedef enum logic [1:0] {
    PH_HEAD = 2'b01,
    PH_TAIL = 2'b10
  } phase_e;

  phase_e      phase;       // Which beat comes next
  logic        framed;      // Beat valid this cycle
  logic        head_beat;   // Framed beat in head phase
  logic        tail_beat;   // Framed beat in tail phase
  head_beat_t  head_q;      // Latched head view
  emesh_tran_t pkt;         // Packet assembled on the tail
  logic        keep;        // Direction matches this channel
  logic        fifo_afull;

  // ####################
  // Beat framing
  // ####################

  assign framed    = (rxi_frame == FRAME_ON);
  assign head_beat = framed && (phase == PH_HEAD);
  assign tail_beat = framed && (phase == PH_TAIL);

  // Phase toggles per framed beat
  // Any gap puts it back to head
  always_ff @(posedge rxi_lclk) begin
    if (reset) begin
      phase <= PH_HEAD;
    end else if (!framed) begin
      phase <= PH_HEAD;                  // Gap so next beat opens a packet
    end else if (head_beat) begin
      phase <= PH_TAIL;
    end else begin
      phase <= PH_HEAD;                  // Tail done
    end
  end

  // Head view kept until the tail shows up
  always_ff @(posedge rxi_lclk) begin
    if (head_beat)
      head_q <= rxi_data.head;
  end

  // ####################
  // Packet assembly
  // ####################

  always_comb begin
    pkt.write    = head_q.hdr.write;
    pkt.datamode = head_q.hdr.datamode;
    pkt.ctrlmode = head_q.hdr.ctrlmode;
    pkt.dstaddr  = head_q.dstaddr;
    pkt.srcaddr  = rxi_data.tail.srcaddr;  // Straight off the wire
    pkt.data     = rxi_data.tail.data;
  end

  // Other channel takes the rest
  assign keep = (pkt.write == TAKE_WRITES);

  // ####################
  // Buffer
  // ####################

  // Tail written on the same edge it is sampled
  link_rx_fifo fifo (
    .rxi_lclk   (rxi_lclk),
    .reset      (reset),
    .push       (tail_beat && keep),
    .push_tran  (pkt),
    .pop        (pop),
    .head_valid (head_valid),
    .head_tran  (head_tran),
    .afull      (fifo_afull)
  );

  // Wait flag one cycle behind the count
  always_ff @(posedge rxi_lclk) begin
    if (reset)
      rxo_wait <= 1'b0;
    else
      rxo_wait <= fifo_afull;
  end

endmodule

`default_nettype wire

/* logic/emesh_rx_arbiter.sv */
// Mesh arbiter that merges write and read channels onto one mesh port with write priority
`timescale 1ns/1ps
`default_nettype none

module emesh_rx_arbiter (
  input  logic                   wr_valid,       // Write channel has a packet
  input  emesh_pkg::emesh_tran_t wr_tran,        // Oldest write
  input  logic                   rd_valid,       // Read channel has a packet
  input  emesh_pkg::emesh_tran_t rd_tran,        // Oldest read
  input  logic                   emesh_wr_wait,  // Mesh stalls everything
  input  logic                   emesh_rd_wait,  // Mesh stalls reads
  output logic                   wr_pop,         // Write taken this cycle
  output logic                   rd_pop,         // Read taken this cycle
  output logic                   emesh_access,   // Transaction on the port
  output emesh_pkg::emesh_tran_t emesh_tran      // Selected transaction
);
  import emesh_pkg::*;

  logic wr_sel;  // Write wins the port
  logic rd_sel;  // Read wins the port

  // ####################
  // Selection
  // ####################

  // Write priority always
  // Reads also blocked by the write wait
  always_comb begin
    wr_sel = wr_valid && !emesh_wr_wait;
    rd_sel = rd_valid && !wr_sel && !emesh_wr_wait && !emesh_rd_wait;
  end

  // ####################
  // Mesh port
  // ####################

  assign emesh_access = wr_sel || rd_sel;
  assign emesh_tran   = wr_sel ? wr_tran : rd_tran;  // Read path when idle

  // Pop on the edge the packet is taken
  assign wr_pop = wr_sel;
  assign rd_pop = rd_sel;

endmodule

`default_nettype wire

/* logic/link_receiver.sv */
// Link receiver top, write and read channel receivers merged onto one mesh port
`timescale 1ns/1ps
`default_nettype none

module link_receiver (
  input  logic                   rxi_lclk,       // Link clock, also mesh side
  input  logic                   reset,          // Sync reset, active high
  input  link_pkg::beat_t        rxi_data,       // Link beat
  input  logic [7:0]             rxi_frame,      // Byte-lane frames
  input  logic                   emesh_wr_wait,  // From mesh
  input  logic                   emesh_rd_wait,  // From mesh
  output logic                   rxo_wr_wait,    // To transmitter, write channel
  output logic                   rxo_rd_wait,    // To transmitter, read channel
  output logic                   emesh_access,   // Mesh transaction valid
  output emesh_pkg::emesh_tran_t emesh_tran      // Mesh transaction
);
  import emesh_pkg::*;

  logic        wr_head_valid;
  emesh_tran_t wr_head_tran;
  logic        wr_pop;
  logic        rd_head_valid;
  emesh_tran_t rd_head_tran;
  logic        rd_pop;

  // ####################
  // Channel receivers
  // ####################

  // Keeps writes only
  link_rx_channel #(.TAKE_WRITES(1'b1)) wr_rx (
    .rxi_lclk   (rxi_lclk),
    .reset      (reset),
    .rxi_data   (rxi_data),
    .rxi_frame  (rxi_frame),
    .pop        (wr_pop),
    .head_valid (wr_head_valid),
    .head_tran  (wr_head_tran),
    .rxo_wait   (rxo_wr_wait)
  );

  // Keeps read requests only
  link_rx_channel #(.TAKE_WRITES(1'b0)) rd_rx (
    .rxi_lclk   (rxi_lclk),
    .reset      (reset),
    .rxi_data   (rxi_data),
    .rxi_frame  (rxi_frame),
    .pop        (rd_pop),
    .head_valid (rd_head_valid),
    .head_tran  (rd_head_tran),
    .rxo_wait   (rxo_rd_wait)
  );

  // ####################
  // Merge
  // ####################

  emesh_rx_arbiter arb (
    .wr_valid      (wr_head_valid),
    .wr_tran       (wr_head_tran),
    .rd_valid      (rd_head_valid),
    .rd_tran       (rd_head_tran),
    .emesh_wr_wait (emesh_wr_wait),
    .emesh_rd_wait (emesh_rd_wait),
    .wr_pop        (wr_pop),
    .rd_pop        (rd_pop),
    .emesh_access  (emesh_access),
    .emesh_tran    (emesh_tran)
  );

endmodule

`default_nettype wire

/* sim/link_receiver_tb.sv */
// Link receiver testbench driving random two-beat packets against queue models
`timescale 1ns/1ps
`default_nettype none

module link_receiver_tb;
  import link_pkg::*;
  import emesh_pkg::*;

  logic        rxi_lclk;
  logic        reset;
  beat_t       rxi_data;
  logic [7:0]  rxi_frame;
  logic        emesh_wr_wait;
  logic        emesh_rd_wait;
  logic        rxo_wr_wait;
  logic        rxo_rd_wait;
  logic        emesh_access;
  emesh_tran_t emesh_tran;

  emesh_tran_t wr_q[$];           // Writes sent, not yet delivered
  emesh_tran_t rd_q[$];           // Reads sent, not yet delivered
  emesh_tran_t wr_front;          // Expected next write
  emesh_tran_t rd_front;          // Expected next read
  logic        wr_pend;           // Model holds an undelivered write
  logic        rd_pend;           // Model holds an undelivered read
  logic        wr_full;           // Model write count at wait threshold
  logic        rd_full;
  logic        took_wr;           // Mid-cycle view of the port
  logic        took_rd;
  logic        idle_chk;          // Quiet window after reset
  logic        toggle_on;         // Random mesh waits
  int          errors;
  int          wr_done;
  int          rd_done;

  link_receiver UUT (
    .rxi_lclk      (rxi_lclk),
    .reset         (reset),
    .rxi_data      (rxi_data),
    .rxi_frame     (rxi_frame),
    .emesh_wr_wait (emesh_wr_wait),
    .emesh_rd_wait (emesh_rd_wait),
    .rxo_wr_wait   (rxo_wr_wait),
    .rxo_rd_wait   (rxo_rd_wait),
    .emesh_access  (emesh_access),
    .emesh_tran    (emesh_tran)
  );

  initial begin
    rxi_lclk = 1'b0;
    forever #10 rxi_lclk = ~rxi_lclk;  // 20 ns period
  end

  // ####################
  // Reference model
  // ####################

  // Pops land on the edge that took the packet, like the DUT FIFOs
  initial begin
    took_wr = 1'b0;
    took_rd = 1'b0;
    forever begin
      @(posedge rxi_lclk);
      #1;
      if (took_wr && wr_q.size() != 0) begin
        void'(wr_q.pop_front());
        wr_done++;
      end
      if (took_rd && rd_q.size() != 0) begin
        void'(rd_q.pop_front());
        rd_done++;
      end
      wr_pend  = (wr_q.size() != 0);    // Tails already sampled by the DUT
      rd_pend  = (rd_q.size() != 0);
      wr_front = wr_pend ? wr_q[0] : '0;
      rd_front = rd_pend ? rd_q[0] : '0;
      wr_full  = (wr_q.size() >= RX_FIFO_AFULL);
      rd_full  = (rd_q.size() >= RX_FIFO_AFULL);
      @(negedge rxi_lclk);
      took_wr = emesh_access && emesh_tran.write;
      took_rd = emesh_access && !emesh_tran.write;
    end
  end

  // ####################
  // Checks
  // ####################

  // Logs one wrong value and counts it
  task automatic log_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    errors++;
  endtask

  a_quiet: assert property (@(posedge rxi_lclk) disable iff (reset)
    idle_chk |-> !emesh_access && !rxo_wr_wait && !rxo_rd_wait)
    else log_error("port or link wait active before any packet");
  a_wr_data: assert property (@(posedge rxi_lclk) disable iff (reset)
    emesh_access && emesh_tran.write |-> wr_pend && emesh_tran == wr_front)
    else log_error($sformatf("write %h, expected %h", emesh_tran, wr_front));
  a_rd_data: assert property (@(posedge rxi_lclk) disable iff (reset)
    emesh_access && !emesh_tran.write |-> rd_pend && emesh_tran == rd_front)
    else log_error($sformatf("read %h, expected %h", emesh_tran, rd_front));
  a_wr_first: assert property (@(posedge rxi_lclk) disable iff (reset)
    emesh_access && !emesh_tran.write |-> !wr_pend)
    else log_error("read taken over a waiting write");
  a_wr_stall: assert property (@(posedge rxi_lclk) disable iff (reset)
    emesh_wr_wait |-> !emesh_access)
    else log_error("access during mesh write wait");
  a_rd_stall: assert property (@(posedge rxi_lclk) disable iff (reset)
    emesh_rd_wait |-> !(emesh_access && !emesh_tran.write))
    else log_error("read during mesh read wait");
  // Wait flag trails the buffered count by one cycle
  a_wr_flag_up: assert property (@(posedge rxi_lclk) disable iff (reset)
    wr_full |=> rxo_wr_wait)
    else log_error("rxo_wr_wait low at threshold");
  a_wr_flag_dn: assert property (@(posedge rxi_lclk) disable iff (reset)
    !wr_full |=> !rxo_wr_wait)
    else log_error("rxo_wr_wait high below threshold");
  a_rd_flag_up: assert property (@(posedge rxi_lclk) disable iff (reset)
    rd_full |=> rxo_rd_wait)
    else log_error("rxo_rd_wait low at threshold");
  a_rd_flag_dn: assert property (@(posedge rxi_lclk) disable iff (reset)
    !rd_full |=> !rxo_rd_wait)
    else log_error("rxo_rd_wait high below threshold");

  // ####################
  // Driver
  // ####################

  task automatic stop_on_timeout(input string what);
    $display("Timeout while %s", what);
    $display("Regression failed");
    $finish;
  endtask

  // Every drive happens 2 ns after the edge
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge rxi_lclk);
    #2;
    if (toggle_on) begin
      r = $urandom();
      emesh_wr_wait = r[0] & r[1];  // Stalls a quarter of cycles
      emesh_rd_wait = r[2];
    end
  endtask

  task automatic drive_idle();
    logic [31:0] r;
    r = $urandom();
    rxi_frame = r[0] ? 8'h00 : {1'b0, r[7:1]};  // Partial frames count as gaps
    rxi_data  = {r, ~r};
    next_cycle();
  endtask

  task automatic send_packet(input logic is_write);
    beat_t       b;
    emesh_tran_t t;
    logic [31:0] r;
    int          n;
    n = 0;
    while (is_write ? rxo_wr_wait : rxo_rd_wait) begin
      drive_idle();
      n++;
      if (n > 100) stop_on_timeout("waiting for a link wait flag to fall");
    end
    r = $urandom();
    b = '0;
    b.head.hdr.write    = is_write;
    b.head.hdr.datamode = r[1:0];
    b.head.hdr.ctrlmode = r[5:2];
    b.head.hdr.spare    = r[6];      // Ignored by the receiver
    b.head.spare        = r[31:8];
    b.head.dstaddr      = $urandom();
    t.write    = is_write;
    t.datamode = r[1:0];
    t.ctrlmode = r[5:2];
    t.dstaddr  = b.head.dstaddr;
    rxi_data   = b;
    rxi_frame  = FRAME_ON;
    next_cycle();
    b.tail.data    = $urandom();     // Tail view replaces the whole word
    b.tail.srcaddr = $urandom();
    t.data    = b.tail.data;
    t.srcaddr = b.tail.srcaddr;
    rxi_data  = b;
    if (is_write) wr_q.push_back(t);
    else rd_q.push_back(t);
    next_cycle();
  endtask

  // Mode 0 writes, 1 reads, 2 mixed
  task automatic send_traffic(input int count, input int mode);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = $urandom();
      if (r[9]) drive_idle();
      if (r[9] && r[8]) drive_idle();
      send_packet((mode == 2) ? r[0] : (mode == 0));
    end
    drive_idle();
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    while (wr_q.size() != 0 || rd_q.size() != 0 || rxo_wr_wait || rxo_rd_wait) begin
      drive_idle();
      n++;
      if (n > 300) stop_on_timeout("draining the mesh port");
    end
  endtask

  task automatic expect_link_wait(input logic is_write);
    int n;
    n = 0;
    while (!(is_write ? rxo_wr_wait : rxo_rd_wait)) begin
      drive_idle();
      n++;
      if (n > 8) stop_on_timeout("waiting for a link wait flag to rise");
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s done, %0d errors so far", name, errors);
  endtask

  // ####################
  // Sequence
  // ####################

  initial begin
    void'($urandom(73612));
    reset         = 1'b1;
    rxi_data      = '0;
    rxi_frame     = 8'h00;
    emesh_wr_wait = 1'b0;
    emesh_rd_wait = 1'b0;
    idle_chk      = 1'b0;
    toggle_on     = 1'b0;
    errors        = 0;
    wr_done       = 0;
    rd_done       = 0;
    repeat (16) @(posedge rxi_lclk);
    #2;
    reset    = 1'b0;
    idle_chk = 1'b1;
    repeat (8) drive_idle();
    idle_chk = 1'b0;
    report_test("reset state");
    send_traffic(40, 0);
    drain_all();
    report_test("write order");
    send_traffic(40, 1);
    drain_all();
    report_test("read order");
    send_traffic(120, 2);
    drain_all();
    report_test("write priority");
    toggle_on = 1'b1;
    send_traffic(120, 2);
    toggle_on     = 1'b0;
    emesh_wr_wait = 1'b0;
    emesh_rd_wait = 1'b0;
    drain_all();
    report_test("mesh back-pressure");
    emesh_wr_wait = 1'b1;            // Full mesh stall
    send_packet(1'b1);
    send_packet(1'b1);
    expect_link_wait(1'b1);
    send_packet(1'b0);
    send_packet(1'b0);
    expect_link_wait(1'b0);
    repeat (4) drive_idle();
    emesh_wr_wait = 1'b0;
    drain_all();
    report_test("link wait");
    $display("Totals: %0d writes, %0d reads delivered, %0d errors", wr_done, rd_done, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* link_receiver.f */
common/link_pkg.sv
common/emesh_pkg.sv
link_rx/link_rx_fifo.sv
link_rx/link_rx_channel.sv
logic/emesh_rx_arbiter.sv
logic/link_receiver.sv
sim/link_receiver_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the link receiver regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module link_receiver_tb \
  -f link_receiver.f \
  -Mdir obj_dir

out=$(./obj_dir/Vlink_receiver_tb)
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Regression passed"; then
  exit 0
else
  exit 1
fi
